//--- design/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// ----------------------------------------
// Core sizing
// ----------------------------------------
`define RV_XLEN      32                 // Data and address width
`define RV_NREGS     32                 // Integer registers, x0 included

// ----------------------------------------
// Fetch start
// ----------------------------------------
`define RV_RESET_PC  32'h0000_0000      // First fetch address after reset

`endif

//--- design/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // ----------------------------------------
    // Opcodes and ALU operations
    // ----------------------------------------
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,                 // add sub and or slt
        OP_IMM    = 7'b0010011,                 // addi
        OP_LOAD   = 7'b0000011,                 // lw
        OP_STORE  = 7'b0100011,                 // sw
        OP_BRANCH = 7'b1100011                  // beq
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101                        // Signed compare
    } alu_op_e;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;                     // Bit 5 picks sub
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;                       // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                     // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                     // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;                      // Sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;                      // Sits where rd[0] would be
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    // ----------------------------------------
    // Control and data request
    // ----------------------------------------
    typedef struct packed {
        logic    reg_write;                     // rd gets write-back data
        logic    alu_src_imm;                   // Operand B from imm_gen
        logic    mem_write;                     // Store this cycle
        logic    mem_to_reg;                    // Write-back from load data
        logic    branch;                        // beq, taken on zero flag
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                we;                // Store strobe
        logic [`RV_XLEN-1:0] addr;              // Byte address
        logic [`RV_XLEN-1:0] wdata;             // Store data, rs2
    } dmem_req_t;

endpackage

//--- design/alu.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module alu
    import rv_core_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_a,            // Operand A, rs1
    input  logic [`RV_XLEN-1:0] i_b,            // Operand B, rs2 or imm
    input  alu_op_e             i_alu_op,       // From control_decoder
    output logic [`RV_XLEN-1:0] o_result,
    output logic                o_zero          // Result is zero, for beq
);

    // ----------------------------------------
    // Operation select
    // ----------------------------------------
    always_comb begin
        case (i_alu_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;      // Also beq compare
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_SLT: o_result = ($signed(i_a) < $signed(i_b)) ? `RV_XLEN'd1 : '0;
            default: o_result = '0;             // Not reachable from decoder
        endcase
    end

    assign o_zero = (o_result == '0);

    // The decoder must only ever hand over one of the five listed codes
    always_comb begin
        a_known_op: assert final (i_alu_op inside {ALU_ADD, ALU_SUB, ALU_AND,
                                                   ALU_OR, ALU_SLT})
            else $error("%0t alu: i_alu_op unlisted code %b", $time, i_alu_op);
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module reg_file (
    input  logic                i_clk,
    input  logic                i_rst_n,        // Sync, active low
    input  logic [4:0]          i_rs1,
    input  logic [4:0]          i_rs2,
    input  logic [4:0]          i_rd,
    input  logic                i_we,           // From ctrl.reg_write
    input  logic [`RV_XLEN-1:0] i_wdata,        // Write-back mux output
    output logic [`RV_XLEN-1:0] o_rdata1,
    output logic [`RV_XLEN-1:0] o_rdata2
);

    logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];  // x0 kept at zero by the write guard

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};             // All registers start at zero
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;              // x0 writes dropped here
        end
    end

    // Read ports, same-cycle
    assign o_rdata1 = regs[i_rs1];
    assign o_rdata2 = regs[i_rs2];

    // x0 must read zero whatever was aimed at it
    a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((i_rs1 != '0) || (o_rdata1 == '0)) && ((i_rs2 != '0) || (o_rdata2 == '0)))
        else $error("%0t reg_file: x0 read %h / %h, expected 0",
                    $time, o_rdata1, o_rdata2);

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module imm_gen
    import rv_core_pkg::*;
(
    input  instr_u              i_instr,        // Raw fetch word
    output logic [`RV_XLEN-1:0] o_imm           // Sign-extended immediate
);

    opcode_e opcode;                            // Format chosen by opcode

    assign opcode = opcode_e'(i_instr.r.opcode);

    // ----------------------------------------
    // Field layout by format
    // ----------------------------------------
    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD: begin              // I-type: addi, lw
                o_imm = {{(`RV_XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
            end
            OP_STORE: begin                     // S-type: split field
                o_imm = {{(`RV_XLEN-12){i_instr.s.imm_hi[6]}},
                         i_instr.s.imm_hi, i_instr.s.imm_lo};
            end
            OP_BRANCH: begin                    // B-type, implied bit 0
                o_imm = {{(`RV_XLEN-12){i_instr.b.imm12}},
                         i_instr.b.imm11,
                         i_instr.b.imm10_5,
                         i_instr.b.imm4_1,
                         1'b0};
            end
            default: begin
                o_imm = '0;                     // R-type and unsupported
            end
        endcase
    end

endmodule

//--- design/control_decoder.sv
`timescale 1ns/1ns

module control_decoder
    import rv_core_pkg::*;
(
    input  logic   i_rst_n,                     // Blocks stores in reset
    input  instr_u i_instr,
    output ctrl_t  o_ctrl
);

    opcode_e opcode;
    logic    [2:0] funct3;
    logic    alt;                               // funct7 bit 5, sub select
    ctrl_t   ctrl;                              // Before reset gating

    assign opcode = opcode_e'(i_instr.r.opcode);
    assign funct3 = i_instr.r.funct3;
    assign alt    = i_instr.r.funct7[5];

    // ----------------------------------------
    // Main decode
    // ----------------------------------------
    always_comb begin
        ctrl = '0;                              // Inactive, acts as no-op
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alt ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;     // Outside the subset
                endcase
            end
            OP_IMM: begin
                if (funct3 == 3'b000) begin     // addi only
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = ALU_ADD;
                end
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin     // lw only
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_to_reg  = 1'b1;
                    ctrl.alu_op      = ALU_ADD; // rs1 + offset
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin     // sw only
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_op      = ALU_ADD;
                end
            end
            OP_BRANCH: begin
                if (funct3 == 3'b000) begin     // beq only
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = ALU_SUB;      // Equal gives zero flag
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        o_ctrl           = ctrl;
        o_ctrl.mem_write = ctrl.mem_write & i_rst_n;   // No store in reset
    end

    // Store and register write are exclusive across the whole subset
    always_comb begin
        a_wr_excl: assert final (!(o_ctrl.mem_write && o_ctrl.reg_write))
            else $error("%0t control_decoder: mem_write and reg_write both 1", $time);
    end

endmodule

//--- design/pc_unit.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module pc_unit (
    input  logic                i_clk,
    input  logic                i_rst_n,        // Sync, active low
    input  logic                i_take_branch,  // branch and zero flag
    input  logic [`RV_XLEN-1:0] i_imm,          // B-type offset
    output logic [`RV_XLEN-1:0] o_pc
);

    logic [`RV_XLEN-1:0] pc_next;

    // ----------------------------------------
    // Next PC
    // ----------------------------------------
    assign pc_next = i_take_branch ? (o_pc + i_imm)     // beq taken
                                   : (o_pc + `RV_XLEN'd4);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_pc <= `RV_RESET_PC;               // Held through first cycle out
        end else begin
            o_pc <= pc_next;
        end
    end

    // Branch offsets from the program must keep fetches on word boundaries
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pc[1:0] == 2'b00)
        else $error("%0t pc_unit: o_pc %h not word aligned", $time, o_pc);

endmodule

//--- design/rv_core_top.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,        // Sync, active low
    output logic [`RV_XLEN-1:0] o_pc,           // Fetch address
    input  logic [`RV_XLEN-1:0] i_instr,        // Fetch data, same cycle
    output dmem_req_t           o_dmem_req,     // Data access request
    input  logic [`RV_XLEN-1:0] i_dmem_rdata    // Load data, same cycle
);

    instr_u              instr;
    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] rdata1;                // rs1
    logic [`RV_XLEN-1:0] rdata2;                // rs2, also store data
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;            // Also data address
    logic [`RV_XLEN-1:0] wb_data;
    logic                zero;
    logic                take_branch;

    assign instr = i_instr;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    control_decoder dec_i (
        .i_rst_n (i_rst_n),
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    imm_gen imm_i (
        .i_instr (instr),
        .o_imm   (imm)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    reg_file rf_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rs1    (instr.r.rs1),
        .i_rs2    (instr.r.rs2),
        .i_rd     (instr.r.rd),
        .i_we     (ctrl.reg_write),
        .i_wdata  (wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rdata2;         // Operand mux

    alu alu_i (
        .i_a      (rdata1),
        .i_b      (alu_b),
        .i_alu_op (ctrl.alu_op),
        .o_result (alu_result),
        .o_zero   (zero)
    );

    assign wb_data     = ctrl.mem_to_reg ? i_dmem_rdata : alu_result;
    assign take_branch = ctrl.branch & zero;                // beq equal

    pc_unit pc_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_take_branch (take_branch),
        .i_imm         (imm),
        .o_pc          (o_pc)
    );

    // Store request, valid within the instruction's own cycle
    assign o_dmem_req = '{we: ctrl.mem_write, addr: alu_result, wdata: rdata2};

endmodule

//--- bench/rv_core_checker.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_core_checker
    import rv_core_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [`RV_XLEN-1:0] i_pc,           // DUT fetch address
    input  dmem_req_t           i_dmem_req,     // DUT data port
    input  dmem_req_t           i_exp,          // Next expected store, we low if none
    output logic [31:0]         o_store_cnt,    // Stores seen after reset
    output logic [31:0]         o_err_cnt
);

    logic [31:0] store_cnt = '0;
    logic [31:0] err_cnt   = '0;
    int          rst_edges = 0;                 // First edge only loads the PC

    assign o_store_cnt = store_cnt;
    assign o_err_cnt   = err_cnt;

    // ----------------------------------------
    // Compare on every rising edge
    // ----------------------------------------
    always @(posedge i_clk) begin
        int n;
        n = 0;
        if (!i_rst_n) begin
            if (rst_edges > 0 && i_pc !== `RV_RESET_PC) begin
                $display("Error %0t: o_pc = 0x%08h, expected 0x%08h",
                         $time, i_pc, `RV_RESET_PC);
                n++;
            end
            if (i_dmem_req.we !== 1'b0) begin       // No store while in reset
                $display("Error %0t: o_dmem_req.we = %b, expected 0", $time, i_dmem_req.we);
                n++;
            end
            rst_edges <= rst_edges + 1;
        end else if (i_dmem_req.we) begin
            if (!i_exp.we) begin
                $display("%0t: a store to 0x%08h appeared where none should be",
                         $time, i_dmem_req.addr);
                n++;
            end else begin
                if (i_dmem_req.addr !== i_exp.addr) begin
                    $display("Error %0t: o_dmem_req.addr = 0x%08h, expected 0x%08h",
                             $time, i_dmem_req.addr, i_exp.addr);
                    n++;
                end
                if (i_dmem_req.wdata !== i_exp.wdata) begin
                    $display("Error %0t: o_dmem_req.wdata = 0x%08h, expected 0x%08h",
                             $time, i_dmem_req.wdata, i_exp.wdata);
                    n++;
                end
            end
            store_cnt <= store_cnt + 1;
        end
        err_cnt <= err_cnt + n;
    end

endmodule

//--- bench/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_core_cfg.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int          TIMEOUT = 40;       // Cycles allowed per store
    localparam logic [31:0] NOP     = 32'h0000_0013;

    logic                clk;
    logic                rst_n;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
    dmem_req_t           dmem_req;
    logic [`RV_XLEN-1:0] dmem_rdata;
    dmem_req_t           exp_req;               // Store the checker wants next
    logic [31:0]         store_cnt;
    logic [31:0]         err_cnt;

    logic [31:0] prog [0:31];                   // Indexed by PC/4
    logic [31:0] dmem [0:63];                   // Word addressed
    string       tname [$];
    dmem_req_t   texp [$];
    logic [31:0] rnd = 32'h0ac7_adc2;
    logic [31:0] a;
    logic [31:0] b;
    int          failed;
    int          ran;
    int          errs_before;
    int          waited;
    logic        timed_out;

    rv_core_top dut_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_pc         (pc),
        .i_instr      (instr),
        .o_dmem_req   (dmem_req),
        .i_dmem_rdata (dmem_rdata)
    );

    rv_core_checker chk_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_pc        (pc),
        .i_dmem_req  (dmem_req),
        .i_exp       (exp_req),
        .o_store_cnt (store_cnt),
        .o_err_cnt   (err_cnt)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [4:0] rs1, rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic add_test(input string name, input logic [31:0] addr, input logic [31:0] data);
        dmem_req_t req;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        tname.push_back(name);
        texp.push_back(req);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Memory models
    // ----------------------------------------
    initial begin
        instr      = NOP;
        dmem_rdata = '0;
        forever begin
            @(negedge clk);
            instr = prog[pc[6:2]];
            #1;                                 // Let the address settle
            dmem_rdata = dmem[dmem_req.addr[7:2]];
        end
    end

    initial begin
        for (int i = 0; i < 64; i++) dmem[i] = 32'hc0de_0000 ^ (i << 2);
        forever begin
            @(posedge clk);
            if (rst_n && dmem_req.we) dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
        end
    end

    // ----------------------------------------
    // Program, table and test loop
    // ----------------------------------------
    initial begin
        rst_n     = 1'b0;
        exp_req   = '0;
        failed    = 0;
        ran       = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 32; i++) prog[i] = NOP;
        prog[0] = enc_sw(5'd0, 5'd0, 12'd40);                          // Fetched all through reset
        rnd = lcg_next(rnd);
        prog[1] = enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, rnd[11:0]);   // x1 = a, two addi
        prog[2] = enc_i(7'b0010011, 3'b000, 5'd1, 5'd1, rnd[27:16]);
        a = sext12(rnd[11:0]) + sext12(rnd[27:16]);
        rnd = lcg_next(rnd);
        prog[3] = enc_i(7'b0010011, 3'b000, 5'd2, 5'd0, rnd[11:0]);   // x2 = b
        prog[4] = enc_i(7'b0010011, 3'b000, 5'd2, 5'd2, rnd[27:16]);
        b = sext12(rnd[11:0]) + sext12(rnd[27:16]);
        prog[5]  = enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);             // add
        prog[6]  = enc_sw(5'd3, 5'd0, 12'd0);
        prog[7]  = enc_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);             // sub
        prog[8]  = enc_sw(5'd4, 5'd0, 12'd4);
        prog[9]  = enc_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);             // and
        prog[10] = enc_sw(5'd5, 5'd0, 12'd8);
        prog[11] = enc_r(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);             // or
        prog[12] = enc_sw(5'd6, 5'd0, 12'd12);
        prog[13] = enc_i(7'b0010011, 3'b000, 5'd7, 5'd0, 12'hffb);     // x7 = -5
        prog[14] = enc_i(7'b0010011, 3'b000, 5'd8, 5'd0, 12'd3);
        prog[15] = enc_r(7'h00, 3'b010, 5'd9, 5'd7, 5'd8);             // slt -5 < 3
        prog[16] = enc_sw(5'd9, 5'd0, 12'd16);
        prog[17] = enc_i(7'b0010011, 3'b000, 5'd0, 5'd0, 12'd77);      // Write to x0
        prog[18] = enc_sw(5'd0, 5'd0, 12'd20);
        prog[19] = enc_i(7'b0000011, 3'b010, 5'd10, 5'd0, 12'd0);      // lw from 0
        prog[20] = enc_r(7'h00, 3'b000, 5'd11, 5'd10, 5'd1);
        prog[21] = enc_sw(5'd11, 5'd0, 12'd24);
        prog[22] = enc_beq(5'd1, 5'd1, 13'd8);                         // Taken
        prog[23] = enc_sw(5'd1, 5'd0, 12'd28);                         // Skipped
        prog[24] = enc_beq(5'd7, 5'd8, 13'd8);                         // Not taken
        prog[25] = enc_sw(5'd8, 5'd0, 12'd32);
        prog[26] = enc_beq(5'd0, 5'd0, 13'd0);                         // Park here
        add_test("store at reset PC", 32'd40, 32'd0);
        add_test("add", 32'd0, a + b);
        add_test("sub", 32'd4, a - b);
        add_test("and", 32'd8, a & b);
        add_test("or", 32'd12, a | b);
        add_test("slt signed", 32'd16, 32'd1);
        add_test("x0 write", 32'd20, 32'd0);
        add_test("lw then add", 32'd24, a + b + a);
        add_test("beq taken and not taken", 32'd32, 32'd3);

        repeat (4) @(negedge clk);              // Reset cycles
        rst_n = 1'b1;
        ran++;
        if (err_cnt == 0) begin
            $display("Test reset: ok");
        end else begin
            $display("Test reset: mismatch");
            failed++;
        end

        foreach (texp[k]) begin
            exp_req     = texp[k];
            errs_before = err_cnt;
            waited      = 0;
            ran++;
            while (store_cnt < k + 1 && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (store_cnt < k + 1) begin
                $display("Test %s: no store appeared within %0d cycles", tname[k], TIMEOUT);
                timed_out = 1'b1;
                failed++;
                break;
            end
            if (err_cnt == errs_before) begin
                $display("Test %s: ok", tname[k]);
            end else begin
                $display("Test %s: mismatch", tname[k]);
                failed++;
            end
        end

        if (!timed_out) begin
            exp_req     = '0;                   // Any store from here is stray
            errs_before = err_cnt;
            ran++;
            repeat (8) @(negedge clk);          // Observation window at the parked PC
            if (err_cnt == errs_before) begin
                $display("Test no stray store: ok");
            end else begin
                $display("Test no stray store: mismatch");
                failed++;
            end
        end

        $display("Summary: %0d run, %0d with errors, %0d checker errors", ran, failed, err_cnt);
        if (failed == 0 && err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/rv_core_pkg.sv
design/alu.sv
design/reg_file.sv
design/imm_gen.sv
design/control_decoder.sv
design/pc_unit.sv
design/rv_core_top.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rv_core_tb -Mdir obj_dir -f sources.f

sim_out=$(./obj_dir/Vrv_core_tb)
echo "$sim_out"

if grep -qx "all tests passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
